// ==== Bender.yml ====
package:
  name: memory_subsystem

sources:
  - files:
      - common/l2_pkg.sv
      - common/l2_requester_if.sv
      - common/l2_memory_if.sv
      - common/local_memory_if.sv
      - src/byte_en_bram.sv
      - l2_arbiter/l2_arbiter.sv
      - l2_arbiter/l2_to_bram.sv
      - src/memory_subsystem.sv
  - target: test
    files:
      - tests/memory_subsystem_properties.sv
      - tests/memory_subsystem_checker.sv
      - tests/memory_subsystem_tb.sv

// ==== common/l2_memory_if.sv ====
interface l2_memory_if #(
    parameter int BRAM_DEPTH = 1024
);
    import l2_pkg::*;

    localparam int ADDR_WIDTH = $clog2(BRAM_DEPTH);

    // granted request, held until ack
    logic request;
    l2_op_t op;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
    logic [BE_WIDTH-1:0] be;

    // response from the memory adaptor
    logic ack;
    logic rvalid;
    logic [DATA_WIDTH-1:0] rdata;

    modport arbiter (output request, op, addr, wdata, be, input ack, rvalid, rdata);
    modport memory (input request, op, addr, wdata, be, output ack, rvalid, rdata);

endinterface

// ==== common/l2_pkg.sv ====
package l2_pkg;

    // word and byte-lane sizes shared by the whole memory side
    localparam int DATA_WIDTH = 32;
    localparam int BE_WIDTH = DATA_WIDTH / 8;

    // operation carried by a requester channel
    typedef enum logic {
        L2_READ  = 1'b0,
        L2_WRITE = 1'b1
    } l2_op_t;

    // l2_to_bram transfer sequence
    typedef enum logic [1:0] {
        XFER_IDLE    = 2'b00,
        XFER_ACCESS  = 2'b01,
        XFER_RESPOND = 2'b10
    } l2_xfer_state_t;

endpackage

// ==== common/l2_requester_if.sv ====
interface l2_requester_if #(
    parameter int BRAM_DEPTH = 1024
);
    import l2_pkg::*;

    localparam int ADDR_WIDTH = $clog2(BRAM_DEPTH);

    // held by the requester until ack
    logic request;
    l2_op_t op;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
    logic [BE_WIDTH-1:0] be;

    // single-cycle pulses back from the arbiter
    logic ack;
    logic rvalid;
    logic [DATA_WIDTH-1:0] rdata;

    modport requester (output request, op, addr, wdata, be, input ack, rvalid, rdata);
    modport arbiter (input request, op, addr, wdata, be, output ack, rvalid, rdata);

endinterface

// ==== common/local_memory_if.sv ====
interface local_memory_if #(
    parameter int BRAM_DEPTH = 1024
);
    import l2_pkg::*;

    localparam int ADDR_WIDTH = $clog2(BRAM_DEPTH);

    logic en;
    logic [ADDR_WIDTH-1:0] addr;
    logic [BE_WIDTH-1:0] be;
    logic [DATA_WIDTH-1:0] data_in;
    // registered, valid the cycle after en
    logic [DATA_WIDTH-1:0] data_out;

    modport master (output en, addr, be, data_in, input data_out);
    modport ram (input en, addr, be, data_in, output data_out);

endinterface

// ==== l2_arbiter/l2_arbiter.sv ====
module l2_arbiter #(
    parameter int NUM_PORTS = 3,
    parameter int BRAM_DEPTH = 1024
) (
    input logic clk,
    input logic reset,
    l2_requester_if.arbiter requesters [NUM_PORTS],
    l2_memory_if.arbiter mem
);
    import l2_pkg::*;

    localparam int ADDR_WIDTH = $clog2(BRAM_DEPTH);
    localparam int PORT_WIDTH = $clog2(NUM_PORTS);

    // flattened copies of the requester channels
    logic [NUM_PORTS-1:0] req;
    l2_op_t op [NUM_PORTS];
    logic [ADDR_WIDTH-1:0] addr [NUM_PORTS];
    logic [DATA_WIDTH-1:0] wdata [NUM_PORTS];
    logic [BE_WIDTH-1:0] be [NUM_PORTS];

    logic xfer_open;
    logic any_req;
    logic [PORT_WIDTH-1:0] last_winner;
    logic [PORT_WIDTH-1:0] next_winner;
    logic [PORT_WIDTH-1:0] sel;
    logic [PORT_WIDTH-1:0] read_port;

    generate
        for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
            assign req[i] = requesters[i].request;
            assign op[i] = requesters[i].op;
            assign addr[i] = requesters[i].addr;
            assign wdata[i] = requesters[i].wdata;
            assign be[i] = requesters[i].be;

            // ack goes to the open winner, rvalid to the port of the last acked access
            assign requesters[i].ack = mem.ack && xfer_open && (last_winner == PORT_WIDTH'(i));
            assign requesters[i].rvalid = mem.rvalid && (read_port == PORT_WIDTH'(i));
            assign requesters[i].rdata = mem.rdata;
        end
    endgenerate

    // first requesting port after the last winner, wrapping around
    always_comb begin
        int idx;
        next_winner = last_winner;
        any_req = 1'b0;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            idx = (int'(last_winner) + k) % NUM_PORTS;
            if (!any_req && req[idx]) begin
                any_req = 1'b1;
                next_winner = PORT_WIDTH'(idx);
            end
        end
    end

    // hold the latched winner while a transfer is open
    assign sel = xfer_open ? last_winner : next_winner;

    assign mem.request = xfer_open || any_req;
    assign mem.op = op[sel];
    assign mem.addr = addr[sel];
    assign mem.wdata = wdata[sel];
    assign mem.be = be[sel];

    always_ff @(posedge clk) begin
        if (reset) begin
            xfer_open <= 1'b0;
            // port 0 is first in line after reset
            last_winner <= PORT_WIDTH'(NUM_PORTS - 1);
            read_port <= '0;
        end else if (!xfer_open && any_req) begin
            xfer_open <= 1'b1;
            last_winner <= next_winner;
        end else if (xfer_open && mem.ack) begin
            xfer_open <= 1'b0;
            read_port <= last_winner;
        end
    end

endmodule

// ==== l2_arbiter/l2_to_bram.sv ====
module l2_to_bram #(
    parameter int BRAM_DEPTH = 1024
) (
    input logic clk,
    input logic reset,
    l2_memory_if.memory mem,
    local_memory_if.master ram
);
    import l2_pkg::*;

    localparam int ADDR_WIDTH = $clog2(BRAM_DEPTH);

    l2_xfer_state_t state;
    l2_xfer_state_t next_state;

    // fields of the accepted request
    l2_op_t op_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [DATA_WIDTH-1:0] wdata_q;
    logic [BE_WIDTH-1:0] be_q;

    always_comb begin
        next_state = state;
        case (state)
            XFER_IDLE: begin
                if (mem.request) begin
                    next_state = XFER_ACCESS;
                end
            end
            XFER_ACCESS: begin
                // writes finish with the ack
                next_state = (op_q == L2_READ) ? XFER_RESPOND : XFER_IDLE;
            end
            XFER_RESPOND: begin
                next_state = XFER_IDLE;
            end
            default: begin
                next_state = XFER_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= XFER_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (state == XFER_IDLE && mem.request) begin
            op_q <= mem.op;
            addr_q <= mem.addr;
            wdata_q <= mem.wdata;
            be_q <= mem.be;
        end
    end

    // one port B access per transfer and no written lanes on reads
    assign ram.en = (state == XFER_ACCESS);
    assign ram.addr = addr_q;
    assign ram.be = (op_q == L2_WRITE) ? be_q : '0;
    assign ram.data_in = wdata_q;

    assign mem.ack = (state == XFER_ACCESS);
    // RAM output register holds the word read in XFER_ACCESS
    assign mem.rvalid = (state == XFER_RESPOND);
    assign mem.rdata = ram.data_out;

endmodule

// ==== src/byte_en_bram.sv ====
module byte_en_bram #(
    parameter int BRAM_DEPTH = 1024
) (
    input logic clk,
    local_memory_if.ram port_a,
    local_memory_if.ram port_b
);
    import l2_pkg::*;

    localparam int BYTE_WIDTH = DATA_WIDTH / BE_WIDTH;

    logic [DATA_WIDTH-1:0] mem [BRAM_DEPTH];

    always_ff @(posedge clk) begin
        if (port_a.en) begin
            for (int i = 0; i < BE_WIDTH; i++) begin
                if (port_a.be[i]) begin
                    mem[port_a.addr][i*BYTE_WIDTH +: BYTE_WIDTH] <=
                        port_a.data_in[i*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
            // read-first returns the word before this cycle's write
            port_a.data_out <= mem[port_a.addr];
        end

        // port B lane writes come last and win on a same-word collision
        if (port_b.en) begin
            for (int i = 0; i < BE_WIDTH; i++) begin
                if (port_b.be[i]) begin
                    mem[port_b.addr][i*BYTE_WIDTH +: BYTE_WIDTH] <=
                        port_b.data_in[i*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
            port_b.data_out <= mem[port_b.addr];
        end
    end

endmodule

// ==== src/memory_subsystem.sv ====
module memory_subsystem #(
    parameter int NUM_PORTS = 3,
    parameter int BRAM_DEPTH = 1024,
    localparam int ADDR_WIDTH = $clog2(BRAM_DEPTH)
) (
    input logic clk,
    input logic reset,

    // instruction fetch on port A
    input logic fetch_en,
    input logic [ADDR_WIDTH-1:0] fetch_addr,
    output logic [l2_pkg::DATA_WIDTH-1:0] fetch_data,

    // l2 requesters, one slice per port
    input logic [NUM_PORTS-1:0] l2_request,
    input l2_pkg::l2_op_t [NUM_PORTS-1:0] l2_op,
    input logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0] l2_addr,
    input logic [NUM_PORTS-1:0][l2_pkg::DATA_WIDTH-1:0] l2_wdata,
    input logic [NUM_PORTS-1:0][l2_pkg::BE_WIDTH-1:0] l2_be,
    output logic [NUM_PORTS-1:0] l2_ack,
    output logic [NUM_PORTS-1:0] l2_rvalid,
    output logic [l2_pkg::DATA_WIDTH-1:0] l2_rdata
);
    import l2_pkg::*;

    l2_requester_if #(.BRAM_DEPTH(BRAM_DEPTH)) l2_req [NUM_PORTS] ();
    l2_memory_if #(.BRAM_DEPTH(BRAM_DEPTH)) mem_bus ();
    local_memory_if #(.BRAM_DEPTH(BRAM_DEPTH)) fetch_bram ();
    local_memory_if #(.BRAM_DEPTH(BRAM_DEPTH)) data_bram ();

    generate
        for (genvar i = 0; i < NUM_PORTS; i++) begin : g_l2
            assign l2_req[i].request = l2_request[i];
            assign l2_req[i].op = l2_op[i];
            assign l2_req[i].addr = l2_addr[i];
            assign l2_req[i].wdata = l2_wdata[i];
            assign l2_req[i].be = l2_be[i];
            assign l2_ack[i] = l2_req[i].ack;
            assign l2_rvalid[i] = l2_req[i].rvalid;
        end
    endgenerate

    // rdata is the same on every channel
    assign l2_rdata = l2_req[0].rdata;

    // fetch port only reads
    assign fetch_bram.en = fetch_en;
    assign fetch_bram.addr = fetch_addr;
    assign fetch_bram.be = '0;
    assign fetch_bram.data_in = '0;
    assign fetch_data = fetch_bram.data_out;

    l2_arbiter #(
        .NUM_PORTS(NUM_PORTS),
        .BRAM_DEPTH(BRAM_DEPTH)
    ) i_l2_arbiter (
        .clk(clk),
        .reset(reset),
        .requesters(l2_req),
        .mem(mem_bus)
    );

    l2_to_bram #(
        .BRAM_DEPTH(BRAM_DEPTH)
    ) i_l2_to_bram (
        .clk(clk),
        .reset(reset),
        .mem(mem_bus),
        .ram(data_bram)
    );

    byte_en_bram #(
        .BRAM_DEPTH(BRAM_DEPTH)
    ) i_byte_en_bram (
        .clk(clk),
        .port_a(fetch_bram),
        .port_b(data_bram)
    );

endmodule

// ==== tests/memory_subsystem_checker.sv ====
module memory_subsystem_checker #(
    parameter int NUM_PORTS = 3,
    parameter int BRAM_DEPTH = 1024,
    localparam int ADDR_WIDTH = $clog2(BRAM_DEPTH)
) (
    input logic clk,
    input logic reset,
    input logic fetch_en,
    input logic [ADDR_WIDTH-1:0] fetch_addr,
    input logic [l2_pkg::DATA_WIDTH-1:0] fetch_data,
    input logic [NUM_PORTS-1:0] l2_request,
    input l2_pkg::l2_op_t [NUM_PORTS-1:0] l2_op,
    input logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0] l2_addr,
    input logic [NUM_PORTS-1:0][l2_pkg::DATA_WIDTH-1:0] l2_wdata,
    input logic [NUM_PORTS-1:0][l2_pkg::BE_WIDTH-1:0] l2_be,
    input logic [NUM_PORTS-1:0] l2_ack,
    input logic [NUM_PORTS-1:0] l2_rvalid,
    input logic [l2_pkg::DATA_WIDTH-1:0] l2_rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    import l2_pkg::*;

    int data_errors = 0;
    int protocol_errors = 0;

    // byte-wise reference memory
    logic [7:0] model [BRAM_DEPTH][BE_WIDTH];
    logic [DATA_WIDTH-1:0] read_expect [NUM_PORTS];
    logic [DATA_WIDTH-1:0] fetch_expect;
    logic fetch_pending = 1'b0;
    logic [NUM_PORTS-1:0] served = '0;
    int last_acked = NUM_PORTS - 1;
    logic reset_q = 1'b1;

    function automatic logic [DATA_WIDTH-1:0] model_word(input logic [ADDR_WIDTH-1:0] a);
        logic [DATA_WIDTH-1:0] w;
        for (int b = 0; b < BE_WIDTH; b++) begin
            w[b*8 +: 8] = model[a][b];
        end
        return w;
    endfunction

    // round-robin successor of the last acked port among current requests
    function automatic int expected_winner(input logic [NUM_PORTS-1:0] req, input int last);
        int idx;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            idx = (last + k) % NUM_PORTS;
            if (req[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    always @(negedge clk) begin
        int win;
        if (reset || reset_q) begin
            if (l2_ack !== '0 || l2_rvalid !== '0) begin
                $display("ack or rvalid high during or right after reset at %0t", $time);
                protocol_errors++;
            end
            last_acked = NUM_PORTS - 1;
            served = '0;
            fetch_pending = 1'b0;
        end else begin
            if (fetch_pending && fetch_data !== fetch_expect) begin
                $display("Mismatch at %0t: fetch got %h expected %h",
                         $time, fetch_data, fetch_expect);
                data_errors++;
            end
            // captured before this cycle's writes as port A is read-first
            fetch_pending = fetch_en;
            if (fetch_en) begin
                fetch_expect = model_word(fetch_addr);
            end

            for (int p = 0; p < NUM_PORTS; p++) begin
                if (l2_rvalid[p] && l2_rdata !== read_expect[p]) begin
                    $display("Mismatch at %0t: port %0d read got %h expected %h",
                             $time, p, l2_rdata, read_expect[p]);
                    data_errors++;
                end
            end

            for (int p = 0; p < NUM_PORTS; p++) begin
                if (l2_ack[p]) begin
                    win = expected_winner(l2_request, last_acked);
                    if (win != p) begin
                        $display("Mismatch at %0t: port %0d granted, round-robin expects %0d",
                                 $time, p, win);
                        data_errors++;
                    end
                    if (served[p]) begin
                        $display("port %0d was acknowledged twice for one request at %0t",
                                 p, $time);
                        protocol_errors++;
                    end
                    served[p] = 1'b1;
                    last_acked = p;
                    if (l2_op[p] == L2_READ) begin
                        read_expect[p] = model_word(l2_addr[p]);
                    end else begin
                        for (int b = 0; b < BE_WIDTH; b++) begin
                            if (l2_be[p][b]) begin
                                model[l2_addr[p]][b] = l2_wdata[p][b*8 +: 8];
                            end
                        end
                    end
                end else if (!l2_request[p]) begin
                    served[p] = 1'b0;
                end
            end
        end
        reset_q = reset;
    end

endmodule

// ==== tests/memory_subsystem_properties.sv ====
module memory_subsystem_properties #(
    parameter int NUM_PORTS = 3
) (
    input logic clk,
    input logic reset,
    input logic [NUM_PORTS-1:0] l2_request,
    input l2_pkg::l2_op_t [NUM_PORTS-1:0] l2_op,
    input logic [NUM_PORTS-1:0] l2_ack,
    input logic [NUM_PORTS-1:0] l2_rvalid
);
    timeunit 1ns;
    timeprecision 1ps;

    import l2_pkg::*;

    // failed assertion count
    int failures = 0;

    // one grant and one response at a time
    ack_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(l2_ack))
        else begin
            $error("ack high on more than one port");
            failures++;
        end
    rvalid_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(l2_rvalid))
        else begin
            $error("rvalid high on more than one port");
            failures++;
        end

    generate
        for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
            read_ack_then_rvalid: assert property (@(posedge clk) disable iff (reset)
                (l2_ack[p] && l2_op[p] == L2_READ) |=> l2_rvalid[p])
                else begin
                    $error("port %0d read ack not followed by rvalid", p);
                    failures++;
                end
            rvalid_after_read_ack: assert property (@(posedge clk) disable iff (reset)
                l2_rvalid[p] |-> $past(l2_ack[p] && l2_op[p] == L2_READ))
                else begin
                    $error("port %0d rvalid without a read ack", p);
                    failures++;
                end
            ack_needs_request: assert property (@(posedge clk) disable iff (reset)
                l2_ack[p] |-> l2_request[p])
                else begin
                    $error("port %0d ack without request", p);
                    failures++;
                end
        end
    endgenerate

endmodule

bind memory_subsystem memory_subsystem_properties #(
    .NUM_PORTS(NUM_PORTS)
) i_memory_subsystem_properties (
    .clk(clk),
    .reset(reset),
    .l2_request(l2_request),
    .l2_op(l2_op),
    .l2_ack(l2_ack),
    .l2_rvalid(l2_rvalid)
);

// ==== tests/memory_subsystem_tb.sv ====
module memory_subsystem_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import l2_pkg::*;

    localparam int NUM_PORTS = 3;
    localparam int BRAM_DEPTH = 1024;
    localparam int ADDR_WIDTH = $clog2(BRAM_DEPTH);
    localparam int NUM_ROWS = 20;
    localparam int CYCLE_LIMIT = NUM_ROWS * (NUM_PORTS * 3 + 4) + 10;

    typedef struct {
        logic [NUM_PORTS-1:0] mask;
        l2_op_t op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic [BE_WIDTH-1:0] be;
        logic fetch_en;
        logic [ADDR_WIDTH-1:0] fetch_addr;
        logic random;
    } row_t;

    logic clk;
    logic reset;
    logic fetch_en;
    logic [ADDR_WIDTH-1:0] fetch_addr;
    logic [DATA_WIDTH-1:0] fetch_data;
    logic [NUM_PORTS-1:0] l2_request;
    l2_op_t [NUM_PORTS-1:0] l2_op;
    logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0] l2_addr;
    logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] l2_wdata;
    logic [NUM_PORTS-1:0][BE_WIDTH-1:0] l2_be;
    logic [NUM_PORTS-1:0] l2_ack;
    logic [NUM_PORTS-1:0] l2_rvalid;
    logic [DATA_WIDTH-1:0] l2_rdata;

    row_t rows [NUM_ROWS];
    integer seed = 32'hb53b;
    int cycles = 0;

    memory_subsystem #(
        .NUM_PORTS(NUM_PORTS),
        .BRAM_DEPTH(BRAM_DEPTH)
    ) i_memory_subsystem (.*);

    memory_subsystem_checker #(
        .NUM_PORTS(NUM_PORTS),
        .BRAM_DEPTH(BRAM_DEPTH)
    ) i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles", cycles);
            $display("errors: data %0d protocol %0d assertion %0d", i_checker.data_errors,
                     i_checker.protocol_errors,
                     i_memory_subsystem.i_memory_subsystem_properties.failures);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic row_t make_row(
        input logic [NUM_PORTS-1:0] mask, input l2_op_t op, input int addr,
        input logic [DATA_WIDTH-1:0] wdata, input logic [BE_WIDTH-1:0] be,
        input logic fen, input int faddr, input logic random
    );
        row_t r;
        r.mask = mask;
        r.op = op;
        r.addr = ADDR_WIDTH'(addr);
        r.wdata = wdata;
        r.be = be;
        r.fetch_en = fen;
        r.fetch_addr = ADDR_WIDTH'(faddr);
        r.random = random;
        return r;
    endfunction

    // port p uses word addr+p, so one row touches several words
    task automatic fill_table();
        rows[0] = make_row(3'b111, L2_WRITE, 16, 32'h1000_0a0b, 4'hf, 1'b0, 0, 1'b0);
        rows[1] = make_row(3'b111, L2_WRITE, 19, 32'h2000_0c0d, 4'hf, 1'b0, 0, 1'b0);
        rows[2] = make_row(3'b111, L2_WRITE, 22, 32'h3000_0e0f, 4'hf, 1'b0, 0, 1'b0);
        rows[3] = make_row(3'b001, L2_WRITE, 0, 32'h1122_3344, 4'hf, 1'b0, 0, 1'b0);
        rows[4] = make_row(3'b001, L2_READ, 0, 32'h0, 4'h0, 1'b0, 0, 1'b0);
        rows[5] = make_row(3'b001, L2_WRITE, 4, 32'ha5a5_a5a5, 4'hf, 1'b0, 0, 1'b0);
        rows[6] = make_row(3'b001, L2_WRITE, 4, 32'h00cc_00ee, 4'b0101, 1'b0, 0, 1'b0);
        rows[7] = make_row(3'b001, L2_READ, 4, 32'h0, 4'h0, 1'b0, 0, 1'b0);
        rows[8] = make_row(3'b000, L2_READ, 0, 32'h0, 4'h0, 1'b1, 0, 1'b0);
        rows[9] = make_row(3'b010, L2_WRITE, 3, 32'hdead_beef, 4'hf, 1'b1, 4, 1'b0);
        rows[10] = make_row(3'b000, L2_READ, 0, 32'h0, 4'h0, 1'b1, 4, 1'b0);
        for (int r = 11; r < NUM_ROWS - 1; r++) begin
            rows[r] = make_row(3'b111, L2_READ, 16, 32'h0, 4'hf, 1'b1, 16, 1'b1);
        end
        // all ports again, later in the run
        rows[NUM_ROWS-1] = make_row(3'b111, L2_READ, 16, 32'h0, 4'h0, 1'b1, 20, 1'b0);
    endtask

    task automatic run_row(input row_t r);
        logic [NUM_PORTS-1:0] pending;
        logic [NUM_PORTS-1:0] reads_left;
        l2_op_t [NUM_PORTS-1:0] ops;
        logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0] addrs;
        logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] datas;
        logic [NUM_PORTS-1:0][BE_WIDTH-1:0] bes;
        logic [ADDR_WIDTH-1:0] faddr;
        pending = r.mask;
        reads_left = '0;
        faddr = r.fetch_addr;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (r.random) begin
                // words 16..23 are all written by the first rows
                ops[p] = $random(seed) & 1 ? L2_WRITE : L2_READ;
                addrs[p] = ADDR_WIDTH'(16 + ($random(seed) & 7));
                datas[p] = $random(seed);
                bes[p] = $random(seed);
            end else begin
                ops[p] = r.op;
                addrs[p] = r.addr + ADDR_WIDTH'(p);
                datas[p] = r.wdata ^ (32'h0101_0101 * p);
                bes[p] = r.be;
            end
            if (r.mask[p] && ops[p] == L2_READ) begin
                reads_left[p] = 1'b1;
            end
        end
        if (r.random) begin
            faddr = ADDR_WIDTH'(16 + ($random(seed) & 7));
        end
        @(posedge clk);
        l2_request <= pending;
        l2_op <= ops;
        l2_addr <= addrs;
        l2_wdata <= datas;
        l2_be <= bes;
        fetch_en <= r.fetch_en;
        fetch_addr <= faddr;
        do begin
            @(negedge clk);
            pending = pending & ~l2_ack;
            reads_left = reads_left & ~l2_rvalid;
            @(posedge clk);
            l2_request <= pending;
            fetch_en <= 1'b0;
        end while (pending != '0 || reads_left != '0);
    endtask

    initial begin
        int total;
        reset = 1'b1;
        fetch_en = 1'b0;
        fetch_addr = '0;
        l2_request = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            l2_op[p] = L2_READ;
        end
        l2_addr = '0;
        l2_wdata = '0;
        l2_be = '0;
        fill_table();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end
        // let the last fetch compare land
        repeat (2) @(posedge clk);
        total = i_checker.data_errors + i_checker.protocol_errors
                + i_memory_subsystem.i_memory_subsystem_properties.failures;
        $display("errors: data %0d protocol %0d assertion %0d", i_checker.data_errors,
                 i_checker.protocol_errors,
                 i_memory_subsystem.i_memory_subsystem_properties.failures);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
common/l2_pkg.sv
common/l2_requester_if.sv
common/l2_memory_if.sv
common/local_memory_if.sv
src/byte_en_bram.sv
l2_arbiter/l2_arbiter.sv
l2_arbiter/l2_to_bram.sv
src/memory_subsystem.sv
tests/memory_subsystem_properties.sv
tests/memory_subsystem_checker.sv
tests/memory_subsystem_tb.sv
